/* include/saturn_bus_params.svh */
`ifndef SATURN_BUS_PARAMS_SVH
`define SATURN_BUS_PARAMS_SVH

// ********************
// bus command codes
// ********************

`define BUSCMD_PC_READ   4'h0
`define BUSCMD_DP_READ   4'h1
`define BUSCMD_PC_WRITE  4'h2
`define BUSCMD_DP_WRITE  4'h3
`define BUSCMD_LOAD_PC   4'h4
`define BUSCMD_LOAD_DP   4'h5
`define BUSCMD_CONFIGURE 4'h6
`define BUSCMD_RESET     4'h7

// nibbles per pointer load or configure word
`define SATURN_ADDR_NIBBLES 5

// memory address widths of the two system RAM devices
`define SYSRAM0_BITS 8
`define SYSRAM1_BITS 7

`endif

/* src/saturn_bus_pkg.sv */
`include "saturn_bus_params.svh"

package saturn_bus_pkg;

    // one nibble as it travels on the bus
    typedef logic [3:0] nibble_t;

    // 20-bit nibble address of the Saturn
    typedef logic [`SATURN_ADDR_NIBBLES*4-1:0] saturn_addr_t;

    typedef logic [3:0] bus_cmd_t;  // last command seen on the bus

    // configuration sequence of a device
    // the length comes first, then the base address
    typedef enum logic [1:0] {
        CFG_LENGTH,
        CFG_BASE,
        CFG_DONE
    } cfg_state_t;

endpackage

/* src/saturn_bus_addr_tracker.sv */
`timescale 1ns/1ps

`include "saturn_bus_params.svh"

module saturn_bus_addr_tracker (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_clk_en,
    input  logic                         i_bus_clk_en,
    input  logic                         i_bus_is_data,
    input  saturn_bus_pkg::nibble_t      i_bus_nibble_in,
    input  logic                         i_bus_daisy,
    output logic                         o_configured,
    output logic                         o_active,
    output logic                         o_read_en,
    output logic                         o_write_en,
    output saturn_bus_pkg::saturn_addr_t o_offset
);
    import saturn_bus_pkg::*;

    localparam logic [2:0] LAST_POS = 3'(`SATURN_ADDR_NIBBLES - 1);

    bus_cmd_t     last_cmd;
    logic [2:0]   pos_ctr;      // nibble position inside a load or configure word
    saturn_addr_t local_pc;
    saturn_addr_t local_dp;
    saturn_addr_t length;
    saturn_addr_t base_addr;
    cfg_state_t   cfg_state;

    logic         bus_cycle;
    logic         cmd_cycle;
    logic         data_cycle;
    logic         last_nibble;
    logic         cfg_take;
    logic         do_read;
    logic         do_write;
    logic         use_pc;
    logic         use_dp;
    saturn_addr_t pointer;
    saturn_addr_t window_end;
    logic         in_window;
    saturn_addr_t new_length;
    saturn_addr_t new_base;

    // keeps the nibbles already received below pos, places nib at pos
    // and clears everything above
    function automatic saturn_addr_t insert_nibble(
        input saturn_addr_t value,
        input logic [2:0]   pos,
        input nibble_t      nib
    );
        saturn_addr_t result;
        result = '0;
        for (int i = 0; i < `SATURN_ADDR_NIBBLES; i++) begin
            if (i < pos)
                result[i*4 +: 4] = value[i*4 +: 4];
            else if (i == pos)
                result[i*4 +: 4] = nib;
        end
        return result;
    endfunction

    // ********************
    // bus strobes and decode
    // ********************

    assign bus_cycle   = i_clk_en & i_bus_clk_en;
    assign cmd_cycle   = bus_cycle & ~i_bus_is_data;
    assign data_cycle  = bus_cycle & i_bus_is_data;
    assign last_nibble = (pos_ctr == LAST_POS);

    assign do_read  = (last_cmd == `BUSCMD_PC_READ)  || (last_cmd == `BUSCMD_DP_READ);
    assign do_write = (last_cmd == `BUSCMD_PC_WRITE) || (last_cmd == `BUSCMD_DP_WRITE);
    assign use_pc   = (last_cmd == `BUSCMD_PC_READ)  || (last_cmd == `BUSCMD_PC_WRITE);
    assign use_dp   = (last_cmd == `BUSCMD_DP_READ)  || (last_cmd == `BUSCMD_DP_WRITE);

    assign o_configured = (cfg_state == CFG_DONE);
    assign cfg_take     = i_bus_daisy & ~o_configured;  // only the first unconfigured device

    // ********************
    // window check
    // ********************

    assign pointer    = use_pc ? local_pc : local_dp;
    assign window_end = base_addr + length;
    assign in_window  = (pointer >= base_addr) && (pointer < window_end);

    assign o_active   = (use_pc | use_dp) & o_configured & in_window;
    assign o_read_en  = data_cycle & do_read & o_active;
    assign o_write_en = data_cycle & do_write & o_active;
    assign o_offset   = pointer - base_addr;

    // ********************
    // command and pointers
    // ********************

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd <= '0;
            pos_ctr  <= '0;
            local_pc <= '0;
            local_dp <= '0;
        end else if (cmd_cycle) begin
            last_cmd <= bus_cmd_t'(i_bus_nibble_in);
            pos_ctr  <= '0;                          // every new command restarts a word
        end else if (data_cycle) begin
            case (last_cmd)
                `BUSCMD_PC_READ,
                `BUSCMD_PC_WRITE: local_pc <= local_pc + 1'b1;
                `BUSCMD_DP_READ,
                `BUSCMD_DP_WRITE: local_dp <= local_dp + 1'b1;
                `BUSCMD_LOAD_PC: begin
                    local_pc[pos_ctr*4 +: 4] <= i_bus_nibble_in;
                    pos_ctr <= last_nibble ? 3'd0 : pos_ctr + 3'd1;
                    if (last_nibble)
                        last_cmd <= `BUSCMD_PC_READ;  // auto switch after the fifth nibble
                end
                `BUSCMD_LOAD_DP: begin
                    local_dp[pos_ctr*4 +: 4] <= i_bus_nibble_in;
                    pos_ctr <= last_nibble ? 3'd0 : pos_ctr + 3'd1;
                    if (last_nibble)
                        last_cmd <= `BUSCMD_DP_READ;
                end
                `BUSCMD_CONFIGURE: begin
                    if (cfg_take)
                        pos_ctr <= last_nibble ? 3'd0 : pos_ctr + 3'd1;
                end
                default: begin
                end
            endcase
        end
    end

    // ********************
    // daisy configuration
    // ********************

    assign new_length = insert_nibble(length, pos_ctr, i_bus_nibble_in);
    assign new_base   = insert_nibble(base_addr, pos_ctr, i_bus_nibble_in);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cfg_state <= CFG_LENGTH;
            length    <= '0;
            base_addr <= '0;
        end else if (cmd_cycle) begin
            if (i_bus_nibble_in == `BUSCMD_RESET) begin  // unconfigure
                cfg_state <= CFG_LENGTH;
                length    <= '0;
                base_addr <= '0;
            end
        end else if (data_cycle && (last_cmd == `BUSCMD_CONFIGURE) && cfg_take) begin
            case (cfg_state)
                CFG_LENGTH: begin
                    // length arrives as two's complement, stored negated
                    if (last_nibble) begin
                        length    <= ~new_length + 1'b1;
                        cfg_state <= CFG_BASE;
                    end else begin
                        length <= new_length;
                    end
                end
                CFG_BASE: begin
                    base_addr <= new_base;
                    if (last_nibble)
                        cfg_state <= CFG_DONE;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* src/saturn_sysram.sv */
`timescale 1ns/1ps

module saturn_sysram #(
    parameter int RAM_BITS = 8
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_clk_en,
    input  logic                    i_bus_clk_en,
    input  logic                    i_bus_is_data,
    input  saturn_bus_pkg::nibble_t i_bus_nibble_in,
    input  logic                    i_bus_daisy,
    output saturn_bus_pkg::nibble_t o_bus_nibble_out,
    output logic                    o_bus_daisy,
    output logic                    o_bus_active
);
    import saturn_bus_pkg::*;

    localparam int RAM_DEPTH = 1 << RAM_BITS;

    nibble_t             mem [0:RAM_DEPTH-1];

    logic                configured;
    logic                active;
    logic                read_en;
    logic                write_en;
    saturn_addr_t        offset;    // pointer relative to the window base
    logic [RAM_BITS-1:0] mem_addr;

    // ********************
    // bus side
    // ********************

    saturn_bus_addr_tracker u_tracker (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clk_en        (i_clk_en),
        .i_bus_clk_en    (i_bus_clk_en),
        .i_bus_is_data   (i_bus_is_data),
        .i_bus_nibble_in (i_bus_nibble_in),
        .i_bus_daisy     (i_bus_daisy),
        .o_configured    (configured),
        .o_active        (active),
        .o_read_en       (read_en),
        .o_write_en      (write_en),
        .o_offset        (offset)
    );

    // next device in the chain may configure once this one is done
    assign o_bus_daisy  = configured;
    assign o_bus_active = active;

    // window larger than the array simply wraps
    assign mem_addr = offset[RAM_BITS-1:0];

    // ********************
    // nibble array
    // ********************

    // read data shows up one clock after the data cycle and holds
    always_ff @(posedge i_clk) begin
        if (read_en)
            o_bus_nibble_out <= mem[mem_addr];
    end

    always_ff @(posedge i_clk) begin
        if (write_en)
            mem[mem_addr] <= i_bus_nibble_in;  // same edge as the data cycle
    end

endmodule

/* src/saturn_bus_read_merge.sv */
`timescale 1ns/1ps

module saturn_bus_read_merge (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_dev0_active,
    input  logic                    i_dev1_active,
    input  saturn_bus_pkg::nibble_t i_dev0_nibble,
    input  saturn_bus_pkg::nibble_t i_dev1_nibble,
    input  logic                    i_bus_data_cycle,
    output saturn_bus_pkg::nibble_t o_bus_nibble_out,
    output logic                    o_bus_active,
    output logic                    o_bus_conflict
);
    import saturn_bus_pkg::*;

    logic sel_dev1;     // device 1 answered the last claimed data cycle
    logic both_active;

    assign both_active  = i_dev0_active & i_dev1_active;
    assign o_bus_active = i_dev0_active | i_dev1_active;

    // device 0 wins when both claim the cycle
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sel_dev1 <= 1'b0;
        end else if (i_bus_data_cycle && o_bus_active) begin
            sel_dev1 <= i_dev1_active & ~i_dev0_active;
        end
    end

    // sticky until reset
    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_bus_conflict <= 1'b0;
        else if (i_bus_data_cycle && both_active)
            o_bus_conflict <= 1'b1;
    end

    assign o_bus_nibble_out = sel_dev1 ? i_dev1_nibble : i_dev0_nibble;

endmodule

/* src/saturn_bus_ram_chain.sv */
`timescale 1ns/1ps

`include "saturn_bus_params.svh"

module saturn_bus_ram_chain (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_clk_en,
    input  logic                    i_bus_clk_en,
    input  logic                    i_bus_is_data,
    input  saturn_bus_pkg::nibble_t i_bus_nibble_in,
    input  logic                    i_bus_daisy,
    output saturn_bus_pkg::nibble_t o_bus_nibble_out,
    output logic                    o_bus_daisy,
    output logic                    o_bus_active,
    output logic                    o_bus_conflict
);
    import saturn_bus_pkg::*;

    nibble_t dev0_nibble;
    nibble_t dev1_nibble;
    logic    dev0_active;
    logic    dev1_active;
    logic    daisy_mid;       // high once device 0 is configured
    logic    bus_data_cycle;

    assign bus_data_cycle = i_clk_en & i_bus_clk_en & i_bus_is_data;

    // ********************
    // ram devices
    // ********************

    saturn_sysram #(
        .RAM_BITS (`SYSRAM0_BITS)
    ) u_sysram0 (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clk_en         (i_clk_en),
        .i_bus_clk_en     (i_bus_clk_en),
        .i_bus_is_data    (i_bus_is_data),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .i_bus_daisy      (i_bus_daisy),
        .o_bus_nibble_out (dev0_nibble),
        .o_bus_daisy      (daisy_mid),
        .o_bus_active     (dev0_active)
    );

    saturn_sysram #(
        .RAM_BITS (`SYSRAM1_BITS)
    ) u_sysram1 (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clk_en         (i_clk_en),
        .i_bus_clk_en     (i_bus_clk_en),
        .i_bus_is_data    (i_bus_is_data),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .i_bus_daisy      (daisy_mid),
        .o_bus_nibble_out (dev1_nibble),
        .o_bus_daisy      (o_bus_daisy),   // end of the chain
        .o_bus_active     (dev1_active)
    );

    // ********************
    // return path
    // ********************

    saturn_bus_read_merge u_merge (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_dev0_active    (dev0_active),
        .i_dev1_active    (dev1_active),
        .i_dev0_nibble    (dev0_nibble),
        .i_dev1_nibble    (dev1_nibble),
        .i_bus_data_cycle (bus_data_cycle),
        .o_bus_nibble_out (o_bus_nibble_out),
        .o_bus_active     (o_bus_active),
        .o_bus_conflict   (o_bus_conflict)
    );

endmodule

/* testbench/saturn_bus_ram_chain_props.sv */
`timescale 1ns/1ps

module saturn_bus_ram_chain_props (
    input logic i_clk,
    input logic i_reset,
    input logic i_clk_en,
    input logic i_bus_clk_en,
    input logic i_bus_is_data,
    input logic o_bus_daisy,
    input logic o_bus_active,
    input logic o_bus_conflict
);

    logic data_cycle;

    assign data_cycle = i_clk_en & i_bus_clk_en & i_bus_is_data;

    // ********************
    // reset and sticky flags
    // ********************

    reset_clears_outputs: assert property (@(posedge i_clk)
        i_reset |=> (!o_bus_daisy && !o_bus_active && !o_bus_conflict))
        else $error("outputs still set one clock after reset");

    conflict_is_sticky: assert property (@(posedge i_clk)
        $fell(o_bus_conflict) |-> $past(i_reset))
        else $error("conflict flag cleared without reset");

    // configuration only completes on a data nibble
    daisy_rises_on_data: assert property (@(posedge i_clk)
        $rose(o_bus_daisy) |-> $past(data_cycle))
        else $error("daisy output rose outside a data cycle");

endmodule

bind saturn_bus_ram_chain saturn_bus_ram_chain_props u_props (.*);

/* testbench/tb_saturn_bus_ram_chain.sv */
`timescale 1ns/1ps

`include "saturn_bus_params.svh"

module tb_saturn_bus_ram_chain;
    import saturn_bus_pkg::*;

    localparam int PLANNED_BUS_CYCLES = 400;

    logic         i_clk;
    logic         i_reset;
    logic         i_clk_en;
    logic         i_bus_clk_en;
    logic         i_bus_is_data;
    nibble_t      i_bus_nibble_in;
    logic         i_bus_daisy;
    nibble_t      o_bus_nibble_out;
    logic         o_bus_daisy;
    logic         o_bus_active;
    logic         o_bus_conflict;

    integer       seed = 79;
    bit           daisy_in;         // chain input level for the next bus cycles
    saturn_addr_t win_base [2];
    saturn_addr_t win_len [2];

    // reference model of both devices
    saturn_addr_t m_pc;
    saturn_addr_t m_dp;
    bus_cmd_t     m_cmd;
    int           m_pos [2];
    cfg_state_t   m_cfg [2];
    saturn_addr_t m_acc [2];
    saturn_addr_t m_len [2];
    saturn_addr_t m_base [2];
    nibble_t      m_mem [int];      // sparse array keyed by device * 4096 + offset
    nibble_t      m_out [2];
    bit           m_known [2];
    bit           m_sel;
    bit           m_conflict;

    saturn_bus_ram_chain UUT (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clk_en         (i_clk_en),
        .i_bus_clk_en     (i_bus_clk_en),
        .i_bus_is_data    (i_bus_is_data),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .i_bus_daisy      (i_bus_daisy),
        .o_bus_nibble_out (o_bus_nibble_out),
        .o_bus_daisy      (o_bus_daisy),
        .o_bus_active     (o_bus_active),
        .o_bus_conflict   (o_bus_conflict)
    );

    always #5 i_clk = ~i_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_nibble(input string what, input nibble_t got, input nibble_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input bit exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                                     $time, what, got, exp));
    endtask

    // ********************
    // model
    // ********************

    function automatic saturn_addr_t model_ptr();
        return ((m_cmd == `BUSCMD_PC_READ) || (m_cmd == `BUSCMD_PC_WRITE)) ? m_pc : m_dp;
    endfunction

    function automatic bit model_active(input int d);
        saturn_addr_t ptr;
        bit           ptr_cmd;
        ptr     = model_ptr();
        ptr_cmd = (m_cmd inside {`BUSCMD_PC_READ, `BUSCMD_DP_READ,
                                 `BUSCMD_PC_WRITE, `BUSCMD_DP_WRITE});
        return ptr_cmd && (m_cfg[d] == CFG_DONE) && (ptr >= m_base[d])
               && (ptr < saturn_addr_t'(m_base[d] + m_len[d]));
    endfunction

    task automatic model_step(input bit is_data, input nibble_t nib);
        bit           act [2];
        bit           take [2];
        int           key;
        int           mask;
        saturn_addr_t ptr;
        ptr = model_ptr();
        for (int d = 0; d < 2; d++) begin
            act[d]  = model_active(d);
            take[d] = ((d == 0) ? i_bus_daisy : (m_cfg[0] == CFG_DONE)) && (m_cfg[d] != CFG_DONE);
        end
        if (!is_data) begin
            m_cmd = nib;
            m_pos = '{0, 0};
            if (nib == `BUSCMD_RESET) begin
                m_cfg  = '{CFG_LENGTH, CFG_LENGTH};
                m_len  = '{20'h0, 20'h0};
                m_base = '{20'h0, 20'h0};
            end
        end else begin
            if (act[0] && act[1])
                m_conflict = 1'b1;                // sticky
            if (act[0] || act[1])
                m_sel = act[1] && !act[0];        // device 0 wins an overlap
            for (int d = 0; d < 2; d++) begin
                mask = (1 << (d ? `SYSRAM1_BITS : `SYSRAM0_BITS)) - 1;
                key  = d * 4096 + int'((ptr - m_base[d]) & mask);
                if (act[d] && (m_cmd inside {`BUSCMD_PC_WRITE, `BUSCMD_DP_WRITE}))
                    m_mem[key] = nib;
                if (act[d] && (m_cmd inside {`BUSCMD_PC_READ, `BUSCMD_DP_READ})) begin
                    m_known[d] = m_mem.exists(key);
                    if (m_known[d])
                        m_out[d] = m_mem[key];
                end
                if ((m_cmd == `BUSCMD_CONFIGURE) && take[d]) begin
                    m_acc[d][m_pos[d]*4 +: 4] = nib;
                    if (m_pos[d] == `SATURN_ADDR_NIBBLES - 1) begin
                        m_pos[d] = 0;
                        if (m_cfg[d] == CFG_LENGTH) begin
                            m_len[d] = -m_acc[d];  // length arrives negated
                            m_cfg[d] = CFG_BASE;
                        end else begin
                            m_base[d] = m_acc[d];
                            m_cfg[d]  = CFG_DONE;
                        end
                    end else begin
                        m_pos[d]++;
                    end
                end
            end
            case (m_cmd)
                `BUSCMD_PC_READ, `BUSCMD_PC_WRITE: m_pc++;
                `BUSCMD_DP_READ, `BUSCMD_DP_WRITE: m_dp++;
                `BUSCMD_LOAD_PC, `BUSCMD_LOAD_DP: begin
                    if (m_cmd == `BUSCMD_LOAD_PC)
                        m_pc[m_pos[0]*4 +: 4] = nib;
                    else
                        m_dp[m_pos[0]*4 +: 4] = nib;
                    if (m_pos[0] == `SATURN_ADDR_NIBBLES - 1) begin
                        m_cmd = (m_cmd == `BUSCMD_LOAD_PC) ? `BUSCMD_PC_READ : `BUSCMD_DP_READ;
                        m_pos = '{0, 0};
                    end else begin
                        m_pos = '{m_pos[0] + 1, m_pos[1] + 1};
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    // ********************
    // bus driver
    // ********************

    task automatic apply_reset();
        @(negedge i_clk);
        i_reset      = 1'b1;
        i_clk_en     = 1'b0;
        i_bus_clk_en = 1'b0;
        repeat (2) @(negedge i_clk);
        i_reset    = 1'b0;
        m_pc       = '0;
        m_dp       = '0;
        m_cmd      = '0;
        m_pos      = '{0, 0};
        m_cfg      = '{CFG_LENGTH, CFG_LENGTH};
        m_len      = '{20'h0, 20'h0};
        m_base     = '{20'h0, 20'h0};
        m_sel      = 1'b0;
        m_conflict = 1'b0;                        // memory and read registers keep their data
    endtask

    // one bus cycle plus random idle clocks while an enable is low
    task automatic bus_cycle(input bit is_data, input nibble_t nib);
        bit ce;
        bit bce;
        do begin
            @(negedge i_clk);
            ce              = ($random(seed) & 3) != 0;
            bce             = ($random(seed) & 3) != 0;
            i_clk_en        = ce;
            i_bus_clk_en    = bce;
            i_bus_is_data   = is_data;
            i_bus_nibble_in = nib;
            i_bus_daisy     = daisy_in;
            check_flag("o_bus_active", o_bus_active, model_active(0) || model_active(1));
        end while (!(ce && bce));
        @(posedge i_clk);
        model_step(is_data, nib);
        #1;
        check_flag("o_bus_daisy", o_bus_daisy, m_cfg[1] == CFG_DONE);
        check_flag("o_bus_conflict", o_bus_conflict, m_conflict);
        if (m_known[m_sel])
            check_nibble("o_bus_nibble_out", o_bus_nibble_out, m_out[m_sel]);
    endtask

    task automatic send_word(input bus_cmd_t cmd, input saturn_addr_t value);
        bus_cycle(1'b0, cmd);
        for (int i = 0; i < `SATURN_ADDR_NIBBLES; i++)
            bus_cycle(1'b1, value[i*4 +: 4]);
    endtask

    task automatic configure(input saturn_addr_t base, input saturn_addr_t len);
        saturn_addr_t neg_len;
        neg_len = -len;
        bus_cycle(1'b0, `BUSCMD_CONFIGURE);
        for (int i = 0; i < `SATURN_ADDR_NIBBLES; i++)
            bus_cycle(1'b1, neg_len[i*4 +: 4]);
        for (int i = 0; i < `SATURN_ADDR_NIBBLES; i++)
            bus_cycle(1'b1, base[i*4 +: 4]);
    endtask

    task automatic write_run(input saturn_addr_t start, input int n);
        send_word(`BUSCMD_LOAD_DP, start);
        bus_cycle(1'b0, `BUSCMD_DP_WRITE);
        repeat (n) bus_cycle(1'b1, nibble_t'($random(seed)));
    endtask

    task automatic read_run(input saturn_addr_t start, input int n);
        send_word(`BUSCMD_LOAD_PC, start);        // falls into PC_READ
        repeat (n) bus_cycle(1'b1, nibble_t'($random(seed)));
    endtask

    task automatic write_read_windows();
        saturn_addr_t start;
        int           n;
        for (int d = 0; d < 2; d++) begin
            start = win_base[d] + saturn_addr_t'({$random(seed)} % (win_len[d] - 8));
            n     = 4 + {$random(seed)} % 5;
            write_run(start, n);
            read_run(start, n);
        end
    endtask

    task automatic pick_windows();
        win_base[0] = 20'h10000 | saturn_addr_t'({$random(seed)} & 32'hfff);
        win_len[0]  = 20'd64 + saturn_addr_t'({$random(seed)} & 32'h3f);
        win_base[1] = 20'h40000 | saturn_addr_t'({$random(seed)} & 32'hfff);
        win_len[1]  = 20'd32 + saturn_addr_t'({$random(seed)} & 32'h3f);
    endtask

    initial begin
        #(PLANNED_BUS_CYCLES * 4 * 10);
        report_failure("timeout: the bus sequence did not finish in time");
    end

    initial begin
        i_clk           = 1'b0;
        i_reset         = 1'b0;
        i_clk_en        = 1'b0;
        i_bus_clk_en    = 1'b0;
        i_bus_is_data   = 1'b0;
        i_bus_nibble_in = '0;
        i_bus_daisy     = 1'b0;
        daisy_in        = 1'b0;
        m_known         = '{1'b0, 1'b0};
        apply_reset();

        // reset state and a PC_READ with nothing configured
        check_flag("o_bus_daisy", o_bus_daisy, 1'b0);
        check_flag("o_bus_conflict", o_bus_conflict, 1'b0);
        bus_cycle(1'b0, `BUSCMD_PC_READ);
        bus_cycle(1'b1, 4'h0);

        // daisy chain configuration
        pick_windows();
        configure(win_base[0], win_len[0]);       // ignored while the chain input is low
        check_flag("o_bus_daisy", o_bus_daisy, 1'b0);
        daisy_in = 1'b1;
        configure(win_base[0], win_len[0]);
        check_flag("o_bus_daisy", o_bus_daisy, 1'b0);
        configure(win_base[1], win_len[1]);
        check_flag("o_bus_daisy", o_bus_daisy, 1'b1);

        write_read_windows();

        // window edges of both devices
        for (int d = 0; d < 2; d++) begin
            write_run(win_base[d], 1);
            write_run(win_base[d] + win_len[d] - 1, 1);
            read_run(win_base[d], 1);
            read_run(win_base[d] - 1, 1);
            read_run(win_base[d] + win_len[d] - 1, 1);
            read_run(win_base[d] + win_len[d], 1);
        end

        // overlapping windows
        apply_reset();
        configure(20'h20000, 20'd64);
        configure(20'h20010, 20'd64);
        read_run(20'h20020, 1);
        check_flag("o_bus_conflict", o_bus_conflict, 1'b1);
        read_run(20'h20000, 2);

        // RESET command, then new windows
        bus_cycle(1'b0, `BUSCMD_RESET);
        check_flag("o_bus_daisy", o_bus_daisy, 1'b0);
        pick_windows();
        configure(win_base[0], win_len[0]);
        configure(win_base[1], win_len[1]);
        write_read_windows();

        @(negedge i_clk);
        i_clk_en     = 1'b0;
        i_bus_clk_en = 1'b0;
        $display("All tests passed");
        $finish;
    end

endmodule

/* saturn_bus_ram_chain.f */
+incdir+include
src/saturn_bus_pkg.sv
src/saturn_bus_addr_tracker.sv
src/saturn_sysram.sv
src/saturn_bus_read_merge.sv
src/saturn_bus_ram_chain.sv
testbench/saturn_bus_ram_chain_props.sv
testbench/tb_saturn_bus_ram_chain.sv

/* Bender.yml */
package:
  name: saturn_bus_ram_chain

export_include_dirs:
  - include

sources:
  - files:
      - src/saturn_bus_pkg.sv
      - src/saturn_bus_addr_tracker.sv
      - src/saturn_sysram.sv
      - src/saturn_bus_read_merge.sv
      - src/saturn_bus_ram_chain.sv
  - target: simulation
    files:
      - testbench/saturn_bus_ram_chain_props.sv
      - testbench/tb_saturn_bus_ram_chain.sv
